// File: Makefile
VERILATOR ?= verilator
TOP ?= decode_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) verif/decode_model.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: common/idu_pkg.sv
/*
 * Shared widths, encodings and packet types for the RV32I + Zicsr decode stage.
 * Only mstatus, mtvec, mepc and mcause exist. Other CSR addresses read zero.
 * trap_cause is carried at full word width to match mcause.
 */
package idu_pkg;
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int CSR_ADDR_W = 12;
	localparam int GPR_COUNT  = 32;

	// machine CSR addresses
	localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
	localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

	// mstatus bit positions
	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;

	localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;
	localparam logic [XLEN-1:0] CAUSE_EBREAK  = 32'd3;
	localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
	localparam logic [6:0] OPC_FENCE  = 7'b0001111;

	// funct12 of the privileged SYSTEM instructions
	localparam logic [11:0] F12_ECALL  = 12'h000;
	localparam logic [11:0] F12_EBREAK = 12'h001;
	localparam logic [11:0] F12_MRET   = 12'h302;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_ZIMM
	} imm_kind_t;

	typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;
	typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_CSR} src_b_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_CSR} wb_sel_t;
	typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_t;
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

	typedef enum logic [3:0] {
		JMP_NONE, JMP_JAL, JMP_JALR, JMP_BEQ, JMP_BNE, JMP_BLT,
		JMP_BGE, JMP_BLTU, JMP_BGEU, JMP_MRET, JMP_TRAP
	} jump_t;

	typedef struct packed {
		alu_op_t         alu_op;
		src_a_t          src_a;
		src_b_t          src_b;
		logic            gpr_we;
		wb_sel_t         wb_sel;
		csr_op_t         csr_op;
		logic            mem_read;
		logic            mem_write;
		mem_size_t       mem_size;
		logic            mem_unsigned;
		jump_t           jump;
		logic            trap;
		logic [XLEN-1:0] trap_cause;
	} dec_ctrl_t;

	// no side effects at all, base of every decode
	localparam dec_ctrl_t CTRL_NOP = '{
		alu_op: ALU_ADD, src_a: SRC_A_RS1, src_b: SRC_B_IMM, gpr_we: 1'b0,
		wb_sel: WB_ALU, csr_op: CSR_OP_NONE, mem_read: 1'b0, mem_write: 1'b0,
		mem_size: MEM_WORD, mem_unsigned: 1'b0, jump: JMP_NONE, trap: 1'b0,
		trap_cause: '0
	};

	typedef struct packed {
		logic [XLEN-1:0] instr;
		logic [XLEN-1:0] pc;
	} fetch_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       imm;
		logic [XLEN-1:0]       rs1_data;
		logic [XLEN-1:0]       rs2_data;
		logic [XLEN-1:0]       csr_rdata;
		logic [REG_ADDR_W-1:0] rd;
		logic [CSR_ADDR_W-1:0] csr_addr;
		dec_ctrl_t             ctrl;
	} decode_out_t;

	typedef struct packed {
		logic                  gpr_we;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       gpr_wdata;
		logic                  csr_we;
		logic [CSR_ADDR_W-1:0] csr_addr;
		logic [XLEN-1:0]       csr_wdata;
		logic                  trap;
		logic [XLEN-1:0]       trap_cause;
		logic [XLEN-1:0]       trap_pc;
		logic                  mret;
	} wb_pkt_t;
endpackage

// File: decode/decode_ctrl.sv
/*
 * Main RV32I + Zicsr decoder. It is purely combinational.
 * Unknown encodings decode as a nop with trap set and cause CAUSE_ILLEGAL.
 * CSR ops: the ALU yields rs1 or zimm, and execute merges it with csr_rdata.
 * csrrs/csrrc with a zero rs1 field only read the CSR.
 */
`timescale 1ns/1ps

module decode_ctrl (
	input  logic [idu_pkg::XLEN-1:0] instr,
	output idu_pkg::dec_ctrl_t       ctrl,
	output idu_pkg::imm_kind_t       imm_kind
);
	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        illegal;

	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign funct12 = instr[31:20];

	// alt selects sub / sra
	function automatic idu_pkg::alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
		idu_pkg::alu_op_t op;
		case (f3)
			3'b000: op = alt ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
			3'b001: op = idu_pkg::ALU_SLL;
			3'b010: op = idu_pkg::ALU_SLT;
			3'b011: op = idu_pkg::ALU_SLTU;
			3'b100: op = idu_pkg::ALU_XOR;
			3'b101: op = alt ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
			3'b110: op = idu_pkg::ALU_OR;
			default: op = idu_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl     = idu_pkg::CTRL_NOP;
		imm_kind = idu_pkg::IMM_NONE;
		illegal  = 1'b0;
		case (opcode)
			idu_pkg::OPC_LUI: begin
				ctrl.src_a  = idu_pkg::SRC_A_ZERO;
				ctrl.alu_op = idu_pkg::ALU_PASS_B;
				ctrl.gpr_we = 1'b1;
				imm_kind    = idu_pkg::IMM_U;
			end
			idu_pkg::OPC_AUIPC: begin
				ctrl.src_a  = idu_pkg::SRC_A_PC;
				ctrl.gpr_we = 1'b1;
				imm_kind    = idu_pkg::IMM_U;
			end
			idu_pkg::OPC_JAL: begin
				// alu gives the target, rd gets pc+4
				ctrl.src_a  = idu_pkg::SRC_A_PC;
				ctrl.gpr_we = 1'b1;
				ctrl.wb_sel = idu_pkg::WB_PC4;
				ctrl.jump   = idu_pkg::JMP_JAL;
				imm_kind    = idu_pkg::IMM_J;
			end
			idu_pkg::OPC_JALR: begin
				ctrl.gpr_we = 1'b1;
				ctrl.wb_sel = idu_pkg::WB_PC4;
				ctrl.jump   = idu_pkg::JMP_JALR;
				imm_kind    = idu_pkg::IMM_I;
				illegal     = (funct3 != 3'b000);
			end
			idu_pkg::OPC_BRANCH: begin
				// compare happens in execute on rs1/rs2 data
				ctrl.src_a = idu_pkg::SRC_A_PC;
				imm_kind   = idu_pkg::IMM_B;
				case (funct3)
					3'b000: ctrl.jump = idu_pkg::JMP_BEQ;
					3'b001: ctrl.jump = idu_pkg::JMP_BNE;
					3'b100: ctrl.jump = idu_pkg::JMP_BLT;
					3'b101: ctrl.jump = idu_pkg::JMP_BGE;
					3'b110: ctrl.jump = idu_pkg::JMP_BLTU;
					3'b111: ctrl.jump = idu_pkg::JMP_BGEU;
					default: illegal = 1'b1;
				endcase
			end
			idu_pkg::OPC_LOAD: begin
				ctrl.mem_read     = 1'b1;
				ctrl.gpr_we       = 1'b1;
				ctrl.wb_sel       = idu_pkg::WB_MEM;
				ctrl.mem_unsigned = funct3[2];
				imm_kind          = idu_pkg::IMM_I;
				case (funct3)
					3'b000, 3'b100: ctrl.mem_size = idu_pkg::MEM_BYTE;
					3'b001, 3'b101: ctrl.mem_size = idu_pkg::MEM_HALF;
					3'b010: ctrl.mem_size = idu_pkg::MEM_WORD;
					default: illegal = 1'b1;
				endcase
			end
			idu_pkg::OPC_STORE: begin
				ctrl.mem_write = 1'b1;
				imm_kind       = idu_pkg::IMM_S;
				case (funct3)
					3'b000: ctrl.mem_size = idu_pkg::MEM_BYTE;
					3'b001: ctrl.mem_size = idu_pkg::MEM_HALF;
					3'b010: ctrl.mem_size = idu_pkg::MEM_WORD;
					default: illegal = 1'b1;
				endcase
			end
			idu_pkg::OPC_OPIMM: begin
				ctrl.gpr_we = 1'b1;
				ctrl.alu_op = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
				imm_kind    = idu_pkg::IMM_I;
				// shift-immediates carry funct7 in the upper imm bits
				if (funct3 == 3'b001)
					illegal = (funct7 != 7'b0000000);
				else if (funct3 == 3'b101)
					illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
			end
			idu_pkg::OPC_OP: begin
				ctrl.src_b  = idu_pkg::SRC_B_RS2;
				ctrl.gpr_we = 1'b1;
				ctrl.alu_op = alu_from_f3(funct3, funct7[5]);
				if (funct7 == 7'b0100000)
					illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
				else
					illegal = (funct7 != 7'b0000000);
			end
			idu_pkg::OPC_FENCE: begin
				// single hart, no caches, so fence is a nop
				illegal = (funct3 != 3'b000);
			end
			idu_pkg::OPC_SYSTEM: begin
				if (funct3 == 3'b000) begin
					if (instr[19:7] != '0) begin
						illegal = 1'b1;
					end else begin
						case (funct12)
							idu_pkg::F12_ECALL: begin
								ctrl.trap       = 1'b1;
								ctrl.trap_cause = idu_pkg::CAUSE_ECALL_M;
								ctrl.jump       = idu_pkg::JMP_TRAP;
							end
							idu_pkg::F12_EBREAK: begin
								ctrl.trap       = 1'b1;
								ctrl.trap_cause = idu_pkg::CAUSE_EBREAK;
								ctrl.jump       = idu_pkg::JMP_TRAP;
							end
							idu_pkg::F12_MRET: ctrl.jump = idu_pkg::JMP_MRET;
							default: illegal = 1'b1;
						endcase
					end
				end else if (funct3 == 3'b100) begin
					illegal = 1'b1;
				end else begin
					ctrl.gpr_we = 1'b1;
					ctrl.wb_sel = idu_pkg::WB_CSR;
					// imm forms take zimm, reg forms add a zero imm to rs1
					ctrl.src_a  = funct3[2] ? idu_pkg::SRC_A_ZERO : idu_pkg::SRC_A_RS1;
					imm_kind    = funct3[2] ? idu_pkg::IMM_ZIMM : idu_pkg::IMM_NONE;
					case (funct3[1:0])
						2'b01: ctrl.csr_op = idu_pkg::CSR_OP_WRITE;
						2'b10: ctrl.csr_op = idu_pkg::CSR_OP_SET;
						default: ctrl.csr_op = idu_pkg::CSR_OP_CLEAR;
					endcase
					if (funct3[1] && instr[19:15] == '0)
						ctrl.csr_op = idu_pkg::CSR_OP_NONE;
				end
			end
			default: illegal = 1'b1;
		endcase

		if (illegal) begin
			ctrl            = idu_pkg::CTRL_NOP;
			ctrl.trap       = 1'b1;
			ctrl.trap_cause = idu_pkg::CAUSE_ILLEGAL;
			ctrl.jump       = idu_pkg::JMP_TRAP;
			imm_kind        = idu_pkg::IMM_NONE;
		end
	end
endmodule

// File: decode/decode_stage.sv
/*
 * Decode stage of a multicycle RV32I core. One instruction is in flight.
 * Accept to out_valid takes one cycle. Best case is one instruction per two cycles.
 * out_pkt reads the register files live, so a writeback during the hold shows up.
 * There is no forwarding and no hazard detection.
 */
`timescale 1ns/1ps

module decode_stage (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  idu_pkg::fetch_pkt_t      in_pkt,
	output logic                     in_ready,
	output logic                     out_valid,
	output idu_pkg::decode_out_t     out_pkt,
	input  logic                     exe_ready,
	input  idu_pkg::wb_pkt_t         wb,
	output logic [idu_pkg::XLEN-1:0] mtvec,
	output logic [idu_pkg::XLEN-1:0] mepc
);
	typedef enum logic {ST_IDLE, ST_HOLD} state_t;

	state_t                             state;
	idu_pkg::fetch_pkt_t                held;
	idu_pkg::dec_ctrl_t                 ctrl;
	idu_pkg::imm_kind_t                 imm_kind;
	logic [idu_pkg::XLEN-1:0]           imm;
	logic [idu_pkg::XLEN-1:0]           rs1_data;
	logic [idu_pkg::XLEN-1:0]           rs2_data;
	logic [idu_pkg::XLEN-1:0]           csr_rdata;
	logic [idu_pkg::REG_ADDR_W-1:0]     rs1_addr;
	logic [idu_pkg::REG_ADDR_W-1:0]     rs2_addr;
	logic [idu_pkg::REG_ADDR_W-1:0]     rd_addr;
	logic [idu_pkg::CSR_ADDR_W-1:0]     csr_addr;

	// idle accepts, hold waits for execute
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (in_valid) state <= ST_HOLD;
				ST_HOLD: if (exe_ready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign in_ready  = (state == ST_IDLE);
	assign out_valid = (state == ST_HOLD);

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			held <= in_pkt;
	end

	assign rs1_addr = held.instr[19:15];
	assign rs2_addr = held.instr[24:20];
	assign rd_addr  = held.instr[11:7];
	assign csr_addr = held.instr[31:20];

	decode_ctrl u_decode_ctrl (
		.instr    (held.instr),
		.ctrl     (ctrl),
		.imm_kind (imm_kind)
	);

	imm_sext u_imm_sext (
		.instr (held.instr),
		.kind  (imm_kind),
		.imm   (imm)
	);

	// write address comes from writeback, not from the held instruction
	gpr_file u_gpr_file (
		.clk      (clk),
		.reset    (reset),
		.rs1      (rs1_addr),
		.rs2      (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (wb.gpr_we),
		.rd       (wb.rd),
		.wdata    (wb.gpr_wdata)
	);

	csr_file u_csr_file (
		.clk        (clk),
		.reset      (reset),
		.raddr      (csr_addr),
		.rdata      (csr_rdata),
		.we         (wb.csr_we),
		.waddr      (wb.csr_addr),
		.wdata      (wb.csr_wdata),
		.trap       (wb.trap),
		.trap_cause (wb.trap_cause),
		.trap_pc    (wb.trap_pc),
		.mret       (wb.mret),
		.mtvec      (mtvec),
		.mepc       (mepc)
	);

	always_comb begin
		out_pkt.pc        = held.pc;
		out_pkt.imm       = imm;
		out_pkt.rs1_data  = rs1_data;
		out_pkt.rs2_data  = rs2_data;
		out_pkt.csr_rdata = csr_rdata;
		out_pkt.rd        = rd_addr;
		out_pkt.csr_addr  = csr_addr;
		out_pkt.ctrl      = ctrl;
	end
endmodule

// File: decode/imm_sext.sv
/*
 * Immediate assembly for the RISC-V I, S, B, U and J formats.
 * zimm is the rs1 field zero-extended. The none kind gives zero.
 */
`timescale 1ns/1ps

module imm_sext (
	input  logic [idu_pkg::XLEN-1:0] instr,
	input  idu_pkg::imm_kind_t       kind,
	output logic [idu_pkg::XLEN-1:0] imm
);
	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (kind)
			idu_pkg::IMM_I:
				imm = {{(idu_pkg::XLEN-12){sign}}, instr[31:20]};
			idu_pkg::IMM_S:
				imm = {{(idu_pkg::XLEN-12){sign}}, instr[31:25], instr[11:7]};
			// branch offsets are in half words, bit 0 always zero
			idu_pkg::IMM_B:
				imm = {{(idu_pkg::XLEN-13){sign}}, sign, instr[7], instr[30:25],
					instr[11:8], 1'b0};
			idu_pkg::IMM_U:
				imm = {instr[31:12], 12'b0};
			idu_pkg::IMM_J:
				imm = {{(idu_pkg::XLEN-21){sign}}, sign, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			idu_pkg::IMM_ZIMM:
				imm = {{(idu_pkg::XLEN-5){1'b0}}, instr[19:15]};
			default:
				imm = '0;
		endcase
	end
endmodule

// File: logic/csr_file.sv
/*
 * Machine CSRs mstatus, mtvec, mepc and mcause. Any other address reads zero.
 * mtvec and mepc keep bits 1:0 at zero. Only direct mode, no vectoring.
 * Update priority is trap, then mret, then a write.
 */
`timescale 1ns/1ps

module csr_file (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [idu_pkg::CSR_ADDR_W-1:0] raddr,
	output logic [idu_pkg::XLEN-1:0]       rdata,
	input  logic                           we,
	input  logic [idu_pkg::CSR_ADDR_W-1:0] waddr,
	input  logic [idu_pkg::XLEN-1:0]       wdata,
	input  logic                           trap,
	input  logic [idu_pkg::XLEN-1:0]       trap_cause,
	input  logic [idu_pkg::XLEN-1:0]       trap_pc,
	input  logic                           mret,
	output logic [idu_pkg::XLEN-1:0]       mtvec,
	output logic [idu_pkg::XLEN-1:0]       mepc
);
	logic [idu_pkg::XLEN-1:0] mstatus;
	logic [idu_pkg::XLEN-1:0] mcause;

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (trap) begin
			mepc                         <= {trap_pc[idu_pkg::XLEN-1:2], 2'b00};
			mcause                       <= trap_cause;
			mstatus[idu_pkg::MSTATUS_MPIE] <= mstatus[idu_pkg::MSTATUS_MIE];
			mstatus[idu_pkg::MSTATUS_MIE]  <= 1'b0;
		end else if (mret) begin
			mstatus[idu_pkg::MSTATUS_MIE] <= mstatus[idu_pkg::MSTATUS_MPIE];
		end else if (we) begin
			case (waddr)
				idu_pkg::CSR_MSTATUS: mstatus <= wdata;
				idu_pkg::CSR_MTVEC:   mtvec   <= {wdata[idu_pkg::XLEN-1:2], 2'b00};
				idu_pkg::CSR_MEPC:    mepc    <= {wdata[idu_pkg::XLEN-1:2], 2'b00};
				idu_pkg::CSR_MCAUSE:  mcause  <= wdata;
				default: ;
			endcase
		end
	end

	// read mux, unknown addresses give zero
	always_comb begin
		case (raddr)
			idu_pkg::CSR_MSTATUS: rdata = mstatus;
			idu_pkg::CSR_MTVEC:   rdata = mtvec;
			idu_pkg::CSR_MEPC:    rdata = mepc;
			idu_pkg::CSR_MCAUSE:  rdata = mcause;
			default:              rdata = '0;
		endcase
	end
endmodule

// File: logic/gpr_file.sv
/*
 * 32 x 32 general register file with two combinational reads and one write.
 * x0 reads zero and ignores writes. Reset clears every register.
 */
`timescale 1ns/1ps

module gpr_file (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [idu_pkg::REG_ADDR_W-1:0] rs1,
	input  logic [idu_pkg::REG_ADDR_W-1:0] rs2,
	output logic [idu_pkg::XLEN-1:0]       rs1_data,
	output logic [idu_pkg::XLEN-1:0]       rs2_data,
	input  logic                           we,
	input  logic [idu_pkg::REG_ADDR_W-1:0] rd,
	input  logic [idu_pkg::XLEN-1:0]       wdata
);
	logic [idu_pkg::XLEN-1:0] regs [idu_pkg::GPR_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < idu_pkg::GPR_COUNT; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 hardwired to zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
endmodule

// File: tb.f
+incdir+verif
common/idu_pkg.sv
logic/gpr_file.sv
logic/csr_file.sv
decode/imm_sext.sv
decode/decode_ctrl.sv
decode/decode_stage.sv
verif/decode_tb.sv

// File: verif/decode_model.svh
/*
 * Reference decode rules for the RV32I + Zicsr decode stage, plus the LFSR step.
 * Included inside the testbench module. Only the four machine CSRs exist.
 */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

function automatic idu_pkg::alu_op_t expected_alu(input logic [2:0] f3, input logic alt);
	case (f3)
		3'd0: return alt ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
		3'd1: return idu_pkg::ALU_SLL;
		3'd2: return idu_pkg::ALU_SLT;
		3'd3: return idu_pkg::ALU_SLTU;
		3'd4: return idu_pkg::ALU_XOR;
		3'd5: return alt ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
		3'd6: return idu_pkg::ALU_OR;
		default: return idu_pkg::ALU_AND;
	endcase
endfunction

function automatic void ref_decode(input logic [31:0] ins, output idu_pkg::dec_ctrl_t c,
		output logic [31:0] imm);
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic bad;
	opc = ins[6:0];
	f3 = ins[14:12];
	f7 = ins[31:25];
	bad = 1'b0;
	c = idu_pkg::CTRL_NOP;
	imm = '0;
	case (opc)
		idu_pkg::OPC_LUI: begin
			c.src_a = idu_pkg::SRC_A_ZERO;
			c.alu_op = idu_pkg::ALU_PASS_B;
			c.gpr_we = 1'b1;
			imm = {ins[31:12], 12'h000};
		end
		idu_pkg::OPC_AUIPC: begin
			c.src_a = idu_pkg::SRC_A_PC;
			c.gpr_we = 1'b1;
			imm = {ins[31:12], 12'h000};
		end
		idu_pkg::OPC_JAL: begin
			c.src_a = idu_pkg::SRC_A_PC;
			c.gpr_we = 1'b1;
			c.wb_sel = idu_pkg::WB_PC4;
			c.jump = idu_pkg::JMP_JAL;
			imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		idu_pkg::OPC_JALR: begin
			c.gpr_we = 1'b1;
			c.wb_sel = idu_pkg::WB_PC4;
			c.jump = idu_pkg::JMP_JALR;
			imm = {{20{ins[31]}}, ins[31:20]};
			bad = f3 != 3'd0;
		end
		idu_pkg::OPC_BRANCH: begin
			c.src_a = idu_pkg::SRC_A_PC;
			imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			bad = f3 == 3'd2 || f3 == 3'd3;
			case (f3)
				3'd0: c.jump = idu_pkg::JMP_BEQ;
				3'd1: c.jump = idu_pkg::JMP_BNE;
				3'd4: c.jump = idu_pkg::JMP_BLT;
				3'd5: c.jump = idu_pkg::JMP_BGE;
				3'd6: c.jump = idu_pkg::JMP_BLTU;
				default: c.jump = idu_pkg::JMP_BGEU;
			endcase
		end
		idu_pkg::OPC_LOAD: begin
			c.mem_read = 1'b1;
			c.gpr_we = 1'b1;
			c.wb_sel = idu_pkg::WB_MEM;
			c.mem_unsigned = f3[2];
			c.mem_size = idu_pkg::mem_size_t'(f3[1:0]);
			imm = {{20{ins[31]}}, ins[31:20]};
			bad = f3[1:0] == 2'd3 || f3 == 3'd6;
		end
		idu_pkg::OPC_STORE: begin
			c.mem_write = 1'b1;
			c.mem_size = idu_pkg::mem_size_t'(f3[1:0]);
			imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			bad = f3 > 3'd2;
		end
		idu_pkg::OPC_OPIMM: begin
			c.gpr_we = 1'b1;
			c.alu_op = expected_alu(f3, f3 == 3'd5 && f7 == 7'h20);
			imm = {{20{ins[31]}}, ins[31:20]};
			if (f3 == 3'd1)
				bad = f7 != 7'h00;
			if (f3 == 3'd5)
				bad = f7 != 7'h00 && f7 != 7'h20;
		end
		idu_pkg::OPC_OP: begin
			c.src_b = idu_pkg::SRC_B_RS2;
			c.gpr_we = 1'b1;
			c.alu_op = expected_alu(f3, f7 == 7'h20);
			bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
		end
		idu_pkg::OPC_FENCE:
			bad = f3 != 3'd0;
		idu_pkg::OPC_SYSTEM: begin
			if (f3 == 3'd0) begin
				bad = ins[19:7] != 13'd0;
				if (ins[31:20] == 12'h000 || ins[31:20] == 12'h001) begin
					c.trap = 1'b1;
					c.jump = idu_pkg::JMP_TRAP;
					c.trap_cause = ins[20] ? idu_pkg::CAUSE_EBREAK : idu_pkg::CAUSE_ECALL_M;
				end else if (ins[31:20] == 12'h302) begin
					c.jump = idu_pkg::JMP_MRET;
				end else begin
					bad = 1'b1;
				end
			end else if (f3 == 3'd4) begin
				bad = 1'b1;
			end else begin
				c.gpr_we = 1'b1;
				c.wb_sel = idu_pkg::WB_CSR;
				c.src_a = f3[2] ? idu_pkg::SRC_A_ZERO : idu_pkg::SRC_A_RS1;
				imm = f3[2] ? {27'd0, ins[19:15]} : 32'd0;
				c.csr_op = idu_pkg::csr_op_t'(f3[1:0]);
				// set and clear with rs1 field zero are pure reads
				if (f3[1] && ins[19:15] == 5'd0)
					c.csr_op = idu_pkg::CSR_OP_NONE;
			end
		end
		default: bad = 1'b1;
	endcase
	if (bad) begin
		c = idu_pkg::CTRL_NOP;
		c.trap = 1'b1;
		c.trap_cause = idu_pkg::CAUSE_ILLEGAL;
		c.jump = idu_pkg::JMP_TRAP;
		imm = '0;
	end
endfunction

`endif

// File: verif/decode_tb.sv
/*
 * Testbench for decode_stage. Writebacks are only driven while the stage is idle,
 * so the shadow register copies stay exact. Outputs are sampled on falling edges.
 */
`timescale 1ns/1ps

module decode_tb;
	`include "decode_model.svh"

	localparam int N_RANDOM = 200;
	localparam int N_DIRECTED = 13;
	localparam int CYCLE_LIMIT = 40 * (N_RANDOM + N_DIRECTED) + 200;

	logic clk;
	logic reset;
	logic in_valid;
	idu_pkg::fetch_pkt_t in_pkt;
	logic in_ready;
	logic out_valid;
	idu_pkg::decode_out_t out_pkt;
	logic exe_ready;
	idu_pkg::wb_pkt_t wb;
	logic [31:0] mtvec;
	logic [31:0] mepc;

	logic [15:0] lfsr_state = 16'd51071;
	logic [31:0] gpr_shadow [32];
	logic [31:0] sh_mstatus;
	logic [31:0] sh_mtvec;
	logic [31:0] sh_mepc;
	logic [31:0] sh_mcause;
	idu_pkg::fetch_pkt_t expect_q[$];
	int value_errors = 0;
	int protocol_errors = 0;
	int checked = 0;
	int cycles = 0;

	decode_stage DUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_pkt    (in_pkt),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_pkt   (out_pkt),
		.exe_ready (exe_ready),
		.wb        (wb),
		.mtvec     (mtvec),
		.mepc      (mepc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] csr_expect(input logic [11:0] addr);
		case (addr)
			idu_pkg::CSR_MSTATUS: return sh_mstatus;
			idu_pkg::CSR_MTVEC: return sh_mtvec;
			idu_pkg::CSR_MEPC: return sh_mepc;
			idu_pkg::CSR_MCAUSE: return sh_mcause;
			default: return 32'd0;
		endcase
	endfunction

	task automatic value_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		value_errors++;
	endtask

	// comparison process, one check per output transfer
	always @(negedge clk) begin
		idu_pkg::fetch_pkt_t sent;
		idu_pkg::dec_ctrl_t exp_ctrl;
		logic [31:0] exp_imm;
		if (!reset && out_valid && exe_ready) begin
			if (expect_q.size() == 0) begin
				$display("%0t: decode presented an output with no instruction sent", $time);
				protocol_errors++;
			end else begin
				sent = expect_q.pop_front();
				ref_decode(sent.instr, exp_ctrl, exp_imm);
				if (out_pkt.pc !== sent.pc)
					value_mismatch("pc", out_pkt.pc, sent.pc);
				if (out_pkt.imm !== exp_imm)
					value_mismatch("imm", out_pkt.imm, exp_imm);
				if (out_pkt.rd !== sent.instr[11:7])
					value_mismatch("rd", 32'(out_pkt.rd), 32'(sent.instr[11:7]));
				if (out_pkt.csr_addr !== sent.instr[31:20])
					value_mismatch("csr_addr", 32'(out_pkt.csr_addr), 32'(sent.instr[31:20]));
				if (out_pkt.rs1_data !== gpr_shadow[sent.instr[19:15]])
					value_mismatch("rs1_data", out_pkt.rs1_data, gpr_shadow[sent.instr[19:15]]);
				if (out_pkt.rs2_data !== gpr_shadow[sent.instr[24:20]])
					value_mismatch("rs2_data", out_pkt.rs2_data, gpr_shadow[sent.instr[24:20]]);
				if (out_pkt.csr_rdata !== csr_expect(sent.instr[31:20]))
					value_mismatch("csr_rdata", out_pkt.csr_rdata, csr_expect(sent.instr[31:20]));
				if (out_pkt.ctrl !== exp_ctrl) begin
					$display("FAIL %0t: ctrl for instr %h got %h expected %h", $time,
						sent.instr, out_pkt.ctrl, exp_ctrl);
					value_errors++;
				end
				// a trapping decode must never write state
				if (exp_ctrl.trap && (out_pkt.ctrl.gpr_we || out_pkt.ctrl.mem_write)) begin
					$display("FAIL %0t: trapping instr %h has side effects", $time, sent.instr);
					value_errors++;
				end
				checked++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic send_instr(input logic [31:0] ins, input logic [31:0] pc, input int stall);
		idu_pkg::decode_out_t snap;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
		#2;
		in_valid = 1'b1;
		in_pkt = '{instr: ins, pc: pc};
		exe_ready = (stall == 0);
		expect_q.push_back(in_pkt);
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		in_pkt = '0;
		for (int i = 0; i < stall; i++) begin
			@(negedge clk);
			if (i == 0)
				snap = out_pkt;
			if (!out_valid || in_ready) begin
				$display("%0t: handshake lost its hold during back-pressure", $time);
				protocol_errors++;
			end
			if (out_pkt !== snap) begin
				$display("FAIL %0t: out_pkt changed while stalled", $time);
				value_errors++;
			end
		end
		if (stall > 0) begin
			@(posedge clk);
			#2;
			exe_ready = 1'b1;
		end
		@(negedge clk);
		// still held in the release cycle
		if (stall > 0 && out_pkt !== snap) begin
			$display("FAIL %0t: out_pkt changed while stalled", $time);
			value_errors++;
		end
		while (out_valid)
			@(negedge clk);
		// one cycle after the release edge
		if (!in_ready) begin
			$display("%0t: in_ready did not return after release", $time);
			protocol_errors++;
		end
	endtask

	task automatic wb_gpr(input logic [4:0] rd, input logic [31:0] data);
		@(posedge clk);
		#2;
		wb = '0;
		wb.gpr_we = 1'b1;
		wb.rd = rd;
		wb.gpr_wdata = data;
		if (rd != 5'd0)
			gpr_shadow[rd] = data;
		@(posedge clk);
		#2;
		wb = '0;
	endtask

	task automatic check_redirect();
		@(negedge clk);
		if (mtvec !== sh_mtvec)
			value_mismatch("mtvec output", mtvec, sh_mtvec);
		if (mepc !== sh_mepc)
			value_mismatch("mepc output", mepc, sh_mepc);
	endtask

	task automatic wb_csr(input logic [11:0] addr, input logic [31:0] data);
		@(posedge clk);
		#2;
		wb = '0;
		wb.csr_we = 1'b1;
		wb.csr_addr = addr;
		wb.csr_wdata = data;
		case (addr)
			idu_pkg::CSR_MSTATUS: sh_mstatus = data;
			idu_pkg::CSR_MTVEC: sh_mtvec = data & ~32'd3;
			idu_pkg::CSR_MEPC: sh_mepc = data & ~32'd3;
			idu_pkg::CSR_MCAUSE: sh_mcause = data;
			default: ;
		endcase
		@(posedge clk);
		#2;
		wb = '0;
		check_redirect();
	endtask

	task automatic wb_trap(input logic [31:0] cause, input logic [31:0] pc);
		@(posedge clk);
		#2;
		wb = '0;
		wb.trap = 1'b1;
		wb.trap_cause = cause;
		wb.trap_pc = pc;
		sh_mepc = pc & ~32'd3;
		sh_mcause = cause;
		sh_mstatus[7] = sh_mstatus[3];
		sh_mstatus[3] = 1'b0;
		@(posedge clk);
		#2;
		wb = '0;
		check_redirect();
	endtask

	// csrrs rd, csr, x0
	function automatic logic [31:0] csr_read_instr(input logic [11:0] addr);
		return {addr, 5'd0, 3'b010, 5'd5, idu_pkg::OPC_SYSTEM};
	endfunction

	function automatic logic [31:0] random_instr();
		int cls;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] hi;
		logic [6:0] f7;
		cls = int'(rand_bits(4)) % 11;
		rd = 5'(rand_bits(5));
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		f3 = 3'(rand_bits(3));
		hi = 12'(rand_bits(12));
		f7 = rand_bits(1) ? 7'h20 : 7'h00;
		case (cls)
			0: return {hi, rs1, f3, rd, idu_pkg::OPC_LUI};
			1: return {hi, rs1, f3, rd, idu_pkg::OPC_AUIPC};
			2: return {hi, rs1, f3, rd, idu_pkg::OPC_JAL};
			3: return {hi, rs1, 3'b000, rd, idu_pkg::OPC_JALR};
			4: return {hi[11:5], rs2, rs1, f3, hi[4:0], idu_pkg::OPC_BRANCH};
			5: return {hi, rs1, f3, rd, idu_pkg::OPC_LOAD};
			6: return {hi[11:5], rs2, rs1, f3, hi[4:0], idu_pkg::OPC_STORE};
			7: begin
				if (f3 == 3'd1 || f3 == 3'd5)
					return {(f3 == 3'd1) ? 7'h00 : f7, rs2, rs1, f3, rd, idu_pkg::OPC_OPIMM};
				return {hi, rs1, f3, rd, idu_pkg::OPC_OPIMM};
			end
			8: return {f7, rs2, rs1, f3, rd, idu_pkg::OPC_OP};
			9: begin
				if (f3 == 3'd0 || f3 == 3'd4)
					f3 = 3'b010;
				case (hi[1:0])
					2'd0: hi = idu_pkg::CSR_MSTATUS;
					2'd1: hi = idu_pkg::CSR_MTVEC;
					2'd2: hi = idu_pkg::CSR_MEPC;
					default: hi = rs2[0] ? idu_pkg::CSR_MCAUSE : hi;
				endcase
				return {hi, rs1, f3, rd, idu_pkg::OPC_SYSTEM};
			end
			default: return {hi, rs1, 3'b000, rd, idu_pkg::OPC_FENCE};
		endcase
	endfunction

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_pkt = '0;
		exe_ready = 1'b1;
		wb = '0;
		for (int r = 0; r < 32; r++)
			gpr_shadow[r] = '0;
		sh_mstatus = '0;
		sh_mtvec = '0;
		sh_mepc = '0;
		sh_mcause = '0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		@(negedge clk);
		if (out_valid || !in_ready) begin
			$display("%0t: handshake not idle after reset", $time);
			protocol_errors++;
		end
		if (mtvec !== 32'd0 || mepc !== 32'd0)
			value_mismatch("redirect after reset", mtvec | mepc, 32'd0);

		// CSR write and read back, plus one unsupported address
		wb_csr(idu_pkg::CSR_MSTATUS, rand_bits(32));
		wb_csr(idu_pkg::CSR_MTVEC, rand_bits(32));
		wb_csr(idu_pkg::CSR_MEPC, rand_bits(32));
		wb_csr(idu_pkg::CSR_MCAUSE, rand_bits(32));
		wb_csr(12'h7c0, rand_bits(32));
		send_instr(csr_read_instr(idu_pkg::CSR_MSTATUS), 32'h100, 0);
		send_instr(csr_read_instr(idu_pkg::CSR_MTVEC), 32'h104, 0);
		send_instr(csr_read_instr(idu_pkg::CSR_MEPC), 32'h108, 0);
		send_instr(csr_read_instr(idu_pkg::CSR_MCAUSE), 32'h10c, 0);
		send_instr(csr_read_instr(12'h7c0), 32'h110, 0);
		wb_trap(rand_bits(32), rand_bits(32));
		send_instr(csr_read_instr(idu_pkg::CSR_MEPC), 32'h114, 0);
		send_instr(csr_read_instr(idu_pkg::CSR_MCAUSE), 32'h118, 0);

		// illegal encodings, then ecall, ebreak, mret
		send_instr(32'h0000007f, 32'h200, 0);
		send_instr({7'h01, 5'd2, 5'd1, 3'b000, 5'd3, idu_pkg::OPC_OP}, 32'h204, 0);
		send_instr(32'h10500073, 32'h208, 0);
		send_instr(32'h00000073, 32'h20c, 0);
		send_instr(32'h00100073, 32'h210, 0);
		send_instr(32'h30200073, 32'h214, 0);

		// a write to x0 must be dropped
		wb_gpr(5'd0, 32'hdeadbeef);
		for (int n = 0; n < N_RANDOM; n++) begin
			wb_gpr(5'(rand_bits(5)), rand_bits(32));
			if (rand_bits(2) == 32'd0)
				send_instr(random_instr(), rand_bits(30) << 2, int'(rand_bits(3)) + 1);
			else
				send_instr(random_instr(), rand_bits(30) << 2, 0);
		end

		repeat (4) @(negedge clk);
		if (expect_q.size() != 0) begin
			$display("%0d sent instructions never reached the output", expect_q.size());
			protocol_errors++;
		end
		$display("checked %0d outputs, value errors %0d, protocol errors %0d",
			checked, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
endmodule
